// ==== pp_display_top.f ====
+incdir+common
common/pp_counter_pkg.sv
common/display_pkg.sv
hw/button_conditioner.sv
hw/tick_gen.sv
counter/pp_counter.sv
display/seg_encoder.sv
display/scan_driver.sv
hw/pp_display_top.sv
test/pp_display_asserts.sv
test/pp_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then search the log for the pass line

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f pp_display_top.f \
    --top-module pp_display_tb \
    -Mdir obj_dir -o pp_display_sim > build.log 2>&1 \
    && ./obj_dir/pp_display_sim > sim.log 2>&1 \
    || echo "Build or simulation stopped early, see build.log and sim.log"

grep -qx "NO ERRORS" sim.log 2>/dev/null \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== test/pp_display_tb.sv ====
`timescale 1ns/1ps
`include "pp_defines.svh"

module pp_display_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int TICK_DIV     = `PP_TICK_DIV;
    localparam int SCAN_DIV     = `PP_SCAN_DIV;
    localparam int DEB_LEN      = `PP_DEBOUNCE_LEN;
    // Longest bounce phase is three round trips over the full range
    localparam int BOUNCE_CYCLES = 3 * 2 * 15 * TICK_DIV;
    localparam int TEST_CYCLES   = 6 * RESET_CYCLES + 2 * (BOUNCE_CYCLES + TICK_DIV) +
                                   60 * TICK_DIV;

    logic                       clk;
    logic                       rst_n;
    logic                       enable;
    logic                       flip_btn;
    pp_counter_pkg::count_t     max_val;
    pp_counter_pkg::count_t     min_val;
    pp_counter_pkg::pp_status_t status;
    display_pkg::disp_drive_t   drive;
    int                         errors;

    pp_display_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .flip_btn (flip_btn),
        .max_val  (max_val),
        .min_val  (min_val),
        .status   (status),
        .drive    (drive)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ********************
    // Reference model
    // ********************

    function automatic logic bounds_hold(input pp_counter_pkg::pp_status_t cur,
                                         input pp_counter_pkg::count_t lo,
                                         input pp_counter_pkg::count_t hi);
        return (cur.count < lo) || (cur.count > hi) || (lo == hi);
    endfunction

    // Status after one enabled tick
    function automatic pp_counter_pkg::pp_status_t next_status(
        input pp_counter_pkg::pp_status_t cur,
        input pp_counter_pkg::count_t     lo,
        input pp_counter_pkg::count_t     hi,
        input logic                       pending
    );
        pp_counter_pkg::pp_status_t nxt;
        nxt = cur;
        if (!bounds_hold(cur, lo, hi)) begin
            if (cur.count == hi && cur.up) begin
                nxt.count = cur.count - 4'd1;
                nxt.up    = 1'b0;
            end else if (cur.count == lo && !cur.up) begin
                nxt.count = cur.count + 4'd1;
                nxt.up    = 1'b1;
            end else begin
                nxt.count = cur.up ? cur.count + 4'd1 : cur.count - 4'd1;
                nxt.up    = cur.up ^ pending;
            end
        end
        return nxt;
    endfunction

    function automatic display_pkg::seg_t digit_segments(input int value);
        display_pkg::seg_t seg;
        case (value)
            0:       seg = 8'h03;
            1:       seg = 8'h9F;
            2:       seg = 8'h25;
            3:       seg = 8'h0D;
            4:       seg = 8'h99;
            5:       seg = 8'h49;
            6:       seg = 8'h41;
            7:       seg = 8'h1F;
            8:       seg = 8'h01;
            9:       seg = 8'h09;
            default: seg = 8'hFF;
        endcase
        return seg;
    endfunction

    // Position 3 is the tens digit, 2 the ones digit, 1 and 0 the arrow
    function automatic display_pkg::seg_t expected_seg(input pp_counter_pkg::pp_status_t st,
                                                       input int pos);
        display_pkg::seg_t seg;
        if (pos == 3) begin
            seg = digit_segments(int'(st.count) / 10);
        end else if (pos == 2) begin
            seg = digit_segments(int'(st.count) % 10);
        end else begin
            seg = st.up ? 8'h3B : 8'hC7;
        end
        return seg;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            errors++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Outputs are compared just after each rising edge, once they have settled
    initial begin : compare
        pp_counter_pkg::pp_status_t exp_status;
        pp_counter_pkg::pp_status_t prev_status;
        logic [DEB_LEN-1:0]         samples;
        logic                       level_q;
        logic                       press;
        logic                       tick;
        logic                       pending;
        int                         tick_cnt;
        int                         run_edges;
        int                         sel;
        display_pkg::anode_t        exp_anode;
        run_edges = 0;
        forever begin
            @(posedge clk);
            #1;
            prev_status = exp_status;
            if (!rst_n) begin
                exp_status.count = min_val;
                exp_status.up    = 1'b1;
                pending          = 1'b0;
                samples          = '0;
                level_q          = 1'b0;
                tick_cnt         = 0;
                run_edges        = 0;
            end else begin
                press = (&samples) & ~level_q;
                tick  = (tick_cnt == TICK_DIV - 1);
                if (tick && enable) begin
                    exp_status = next_status(prev_status, min_val, max_val, pending | press);
                    pending    = (pending | press) & bounds_hold(prev_status, min_val, max_val);
                end else begin
                    pending = pending | press;
                end
                level_q  = &samples;
                samples  = {samples[DEB_LEN-2:0], flip_btn};
                tick_cnt = tick ? 0 : tick_cnt + 1;
                run_edges++;
            end
            check_value("status", 32'(status), 32'(exp_status));
            if (run_edges < 2) begin
                check_value("drive", 32'(drive), 32'h0000_0FFF);
            end else begin
                sel       = 3 - ((run_edges - 2) / SCAN_DIV) % 4;
                exp_anode = ~(4'b0001 << sel);
                check_value("drive.anode", 32'(drive.anode), 32'(exp_anode));
                check_value("drive.seg", 32'(drive.seg), 32'(expected_seg(prev_status, sel)));
            end
        end
    end

    // ********************
    // Stimulus
    // ********************

    task automatic run_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apply_reset(input int lo, input int hi);
        min_val = 4'(lo);
        max_val = 4'(hi);
        rst_n   = 1'b0;
        run_cycles(RESET_CYCLES);
        rst_n   = 1'b1;
    endtask

    task automatic press_button(input int len);
        flip_btn = 1'b1;
        run_cycles(len);
        flip_btn = 1'b0;
        run_cycles(DEB_LEN + 2);
    endtask

    initial begin : stimulus
        int lo;
        int hi;
        void'($urandom(32081));
        errors   = 0;
        clk      = 1'b0;
        rst_n    = 1'b0;
        enable   = 1'b0;
        flip_btn = 1'b0;
        min_val  = 4'd3;
        max_val  = 4'd9;

        apply_reset(3, 9);
        run_cycles(2 * TICK_DIV);

        // Several full bounces between random bounds
        for (int round = 0; round < 2; round++) begin
            lo = int'($urandom % 7);
            hi = lo + 3 + int'($urandom % (13 - lo));
            apply_reset(lo, hi);
            enable = 1'b1;
            run_cycles(3 * 2 * (hi - lo) * TICK_DIV + TICK_DIV);
        end

        // Early flip mid-range, then a glitch too short to count
        apply_reset(0, 15);
        enable = 1'b1;
        run_cycles(5 * TICK_DIV);
        press_button(DEB_LEN + 2);
        run_cycles(4 * TICK_DIV);
        press_button(DEB_LEN - 1);
        run_cycles(4 * TICK_DIV);

        enable = 1'b0;
        run_cycles(4 * TICK_DIV);
        // Equal bounds keep the count at the reset value
        enable = 1'b1;
        apply_reset(7, 7);
        run_cycles(4 * TICK_DIV);
        // Bounds that move away from the count leave it stuck
        apply_reset(8, 12);
        run_cycles(2 * TICK_DIV);
        min_val = 4'd0;
        max_val = 4'd5;
        run_cycles(4 * TICK_DIV);
        min_val = 4'd8;
        max_val = 4'd12;
        run_cycles(4 * TICK_DIV);

        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("ERRORS FOUND");
        $fatal(1, "Timeout");
    end

endmodule

// ==== test/pp_display_asserts.sv ====
`timescale 1ns/1ps

module pp_display_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       tick,
    input logic                       enable,
    input pp_counter_pkg::count_t     min_val,
    input pp_counter_pkg::count_t     max_val,
    input pp_counter_pkg::pp_status_t status,
    input display_pkg::disp_drive_t   drive
);

    // At most one digit is lit
    assert property (@(posedge clk) disable iff (!rst_n)
        (drive.anode == 4'b1111) || $onehot(~drive.anode))
        else $error("Anode drive is neither one-hot nor all off");

    // The counter moves only on the edge that ends an enabled tick
    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$stable(status)) |-> $past(tick && enable))
        else $error("Status changed without a preceding tick");

    // ********************
    // Range
    // ********************

    // A step taken from inside the bounds lands inside them
    assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$stable(status.count) &&
         $past(status.count) >= $past(min_val) && $past(status.count) <= $past(max_val))
        |-> (status.count >= $past(min_val) && status.count <= $past(max_val)))
        else $error("Count stepped outside the min to max range");

endmodule

bind pp_display_top pp_display_asserts u_pp_display_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .tick    (tick),
    .enable  (enable),
    .min_val (min_val),
    .max_val (max_val),
    .status  (status),
    .drive   (drive)
);

// ==== hw/pp_display_top.sv ====
`timescale 1ns/1ps
`include "pp_defines.svh"

module pp_display_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       enable,
    input  logic                       flip_btn,
    input  pp_counter_pkg::count_t     max_val,
    input  pp_counter_pkg::count_t     min_val,
    output pp_counter_pkg::pp_status_t status,
    output display_pkg::disp_drive_t   drive
);

    logic                    flip_pulse;
    logic                    tick;
    display_pkg::seg_frame_t frame;

    // ********************
    // Counter side
    // ********************

    button_conditioner u_button_conditioner (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (flip_btn),
        .press (flip_pulse)
    );

    tick_gen #(
        .TICK_DIV (`PP_TICK_DIV)
    ) u_tick_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    pp_counter u_pp_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (enable),
        .tick    (tick),
        .flip    (flip_pulse),
        .max_val (max_val),
        .min_val (min_val),
        .status  (status)
    );

    // ********************
    // Display side
    // ********************

    seg_encoder u_seg_encoder (
        .status (status),
        .frame  (frame)
    );

    scan_driver #(
        .SCAN_DIV (`PP_SCAN_DIV)
    ) u_scan_driver (
        .clk   (clk),
        .rst_n (rst_n),
        .frame (frame),
        .drive (drive)
    );

endmodule

// ==== display/scan_driver.sv ====
`timescale 1ns/1ps
`include "pp_defines.svh"

module scan_driver #(
    parameter int SCAN_DIV = `PP_SCAN_DIV
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  display_pkg::seg_frame_t  frame,
    output display_pkg::disp_drive_t drive
);

    localparam int DWELL_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(SCAN_DIV - 1);

    display_pkg::scan_state_e state_q;
    logic [DWELL_W-1:0]       dwell_q;
    display_pkg::digit_sel_t  sel_q;
    display_pkg::anode_t      anode;
    display_pkg::seg_t        seg;

    // Anode and pattern for the selected position
    always_comb begin
        case (sel_q)
            2'd3: begin
                anode = 4'b0111;
                seg   = frame.d3;
            end
            2'd2: begin
                anode = 4'b1011;
                seg   = frame.d2;
            end
            2'd1: begin
                anode = 4'b1101;
                seg   = frame.d1;
            end
            default: begin
                anode = 4'b1110;
                seg   = frame.d0;
            end
        endcase
    end

    // Scan runs from the leftmost digit to the right
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= display_pkg::SCAN_BLANK;
            dwell_q <= '0;
            sel_q   <= 2'd3;
            drive   <= '1;
        end else begin
            case (state_q)
                display_pkg::SCAN_BLANK: begin
                    state_q <= display_pkg::SCAN_RUN;
                end
                display_pkg::SCAN_RUN: begin
                    drive.anode <= anode;
                    drive.seg   <= seg;
                    if (dwell_q == DWELL_LAST) begin
                        dwell_q <= '0;
                        sel_q   <= sel_q - 1'b1;
                    end else begin
                        dwell_q <= dwell_q + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== display/seg_encoder.sv ====
`timescale 1ns/1ps

module seg_encoder (
    input  pp_counter_pkg::pp_status_t status,
    output display_pkg::seg_frame_t    frame
);

    localparam display_pkg::seg_t SEG_UP   = 8'b0011_1011;
    localparam display_pkg::seg_t SEG_DOWN = 8'b1100_0111;
    localparam pp_counter_pkg::count_t TEN = pp_counter_pkg::count_t'(10);

    // Decimal digit to segments, anything above 9 stays dark
    function automatic display_pkg::seg_t digit_pattern(input pp_counter_pkg::count_t value);
        display_pkg::seg_t pattern;
        case (value)
            4'd0:    pattern = 8'b0000_0011;
            4'd1:    pattern = 8'b1001_1111;
            4'd2:    pattern = 8'b0010_0101;
            4'd3:    pattern = 8'b0000_1101;
            4'd4:    pattern = 8'b1001_1001;
            4'd5:    pattern = 8'b0100_1001;
            4'd6:    pattern = 8'b0100_0001;
            4'd7:    pattern = 8'b0001_1111;
            4'd8:    pattern = 8'b0000_0001;
            4'd9:    pattern = 8'b0000_1001;
            default: pattern = 8'b1111_1111;
        endcase
        return pattern;
    endfunction

    logic                   tens;
    pp_counter_pkg::count_t ones;

    always_comb begin
        tens = (status.count >= TEN);
        ones = tens ? status.count - TEN : status.count;
    end

    // ********************
    // Frame
    // ********************
    always_comb begin
        frame.d3 = digit_pattern(pp_counter_pkg::count_t'(tens));
        frame.d2 = digit_pattern(ones);
        // Both right digits show the direction arrow
        frame.d1 = status.up ? SEG_UP : SEG_DOWN;
        frame.d0 = status.up ? SEG_UP : SEG_DOWN;
    end

endmodule

// ==== counter/pp_counter.sv ====
`timescale 1ns/1ps

module pp_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       enable,
    input  logic                       tick,
    input  logic                       flip,
    input  pp_counter_pkg::count_t     max_val,
    input  pp_counter_pkg::count_t     min_val,
    output pp_counter_pkg::pp_status_t status
);

    pp_counter_pkg::pp_status_t status_d;
    logic                       pending_q;
    logic                       pending;
    logic                       hold;
    logic                       step;

    // A press in the same cycle as the tick already counts
    assign pending = pending_q | flip;

    assign hold = (status.count > max_val) || (status.count < min_val) ||
                  (max_val == min_val);

    // ********************
    // Next count
    // ********************
    always_comb begin
        status_d = status;
        step     = ~hold;
        if (!hold) begin
            if (status.count == max_val && status.up) begin
                status_d.count = status.count - 1'b1;
                status_d.up    = 1'b0;
            end else if (status.count == min_val && !status.up) begin
                status_d.count = status.count + 1'b1;
                status_d.up    = 1'b1;
            end else begin
                status_d.count = status.up ? status.count + 1'b1 : status.count - 1'b1;
                // An early flip takes effect from the following step on
                status_d.up    = status.up ^ pending;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status.count <= min_val;
            status.up    <= 1'b1;
            pending_q    <= 1'b0;
        end else if (tick && enable) begin
            status    <= status_d;
            pending_q <= pending & ~step;
        end else begin
            pending_q <= pending;
        end
    end

endmodule

// ==== hw/tick_gen.sv ====
`timescale 1ns/1ps
`include "pp_defines.svh"

module tick_gen #(
    parameter int TICK_DIV = `PP_TICK_DIV
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (tick) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Strobe in the last cycle of each period
    assign tick = (cnt_q == CNT_LAST);

endmodule

// ==== hw/button_conditioner.sv ====
`timescale 1ns/1ps
`include "pp_defines.svh"

module button_conditioner (
    input  logic clk,
    input  logic rst_n,
    input  logic btn,
    output logic press
);

    localparam int LEN = `PP_DEBOUNCE_LEN;

    logic [LEN-1:0] samples_q;
    logic           level;
    logic           level_q;

    // Newest sample enters at bit 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            samples_q <= '0;
            level_q   <= 1'b0;
        end else begin
            samples_q <= {samples_q[LEN-2:0], btn};
            level_q   <= level;
        end
    end

    // The button counts as pressed only after LEN high samples in a row
    assign level = &samples_q;

    // One pulse per press, however long the button is held
    assign press = level & ~level_q;

endmodule

// ==== common/display_pkg.sv ====
package display_pkg;

    // ********************
    // Display types
    // ********************

    // Segment pattern, active low
    // Segment a sits in the MSB, the decimal point in the LSB
    typedef logic [7:0] seg_t;

    // Digit anodes, active low, one-hot while a digit is lit
    typedef logic [3:0] anode_t;

    // Digit position, 3 is the leftmost digit
    typedef logic [1:0] digit_sel_t;

    // Patterns for all four digits
    typedef struct packed {
        seg_t d3;
        seg_t d2;
        seg_t d1;
        seg_t d0;
    } seg_frame_t;

    // Pins toward the display
    typedef struct packed {
        anode_t anode;
        seg_t   seg;
    } disp_drive_t;

    typedef enum logic {
        SCAN_BLANK,
        SCAN_RUN
    } scan_state_e;

endpackage

// ==== common/pp_counter_pkg.sv ====
`include "pp_defines.svh"

package pp_counter_pkg;

    // ********************
    // Counter types
    // ********************

    // Count value, also used for the min and max bounds
    typedef logic [`PP_COUNT_W-1:0] count_t;

    // Counter state as seen by the rest of the design
    // up is high while the counter climbs toward max
    typedef struct packed {
        count_t count;
        logic   up;
    } pp_status_t;

endpackage

// ==== common/pp_defines.svh ====
`ifndef PP_DEFINES_SVH
`define PP_DEFINES_SVH

// ********************
// Counter
// ********************

// Width of the count and of both bounds
`define PP_COUNT_W 4

// Clock cycles between two counter steps
`define PP_TICK_DIV 8

// ********************
// Button and display
// ********************

// Consecutive high samples before a press is accepted
`define PP_DEBOUNCE_LEN 4

// Clock cycles that each digit stays lit
`define PP_SCAN_DIV 2

`endif
